//--- project.f
source/host_msg_pkg.sv
source/msg_fifo.sv
source/msg_forward.sv
source/host_msg_loop.sv
sim/tb_clock_gen.sv
sim/tb_host_msg_loop.sv

//--- Bender.yml
package:
  name: host_msg_loop

# RTL first, package before its users
sources:
  - source/host_msg_pkg.sv
  - source/msg_fifo.sv
  - source/msg_forward.sv
  - source/host_msg_loop.sv

  # Testbench, top module tb_host_msg_loop
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_host_msg_loop.sv

//--- sim/tb_host_msg_loop.sv
`timescale 1ns/100ps

module tb_host_msg_loop
  import host_msg_pkg::*;
();

  localparam int IN_DEPTH      = IN_DEPTH_DEFAULT;
  localparam int OUT_DEPTH     = OUT_DEPTH_DEFAULT;
  // Words held with no reads at all
  localparam int KEEP_NO_READ  = IN_DEPTH + 1 + OUT_DEPTH;
  localparam logic [31:0] SEED = 32'h94878f44;
  localparam int RESET_CYCLES  = 16;
  localparam int DRIVE_DELAY   = 1;
  localparam int WAIT_LIMIT    = 200;
  localparam int RUN_LIMIT     = 2000;
  localparam int MAX_TESTS     = 8;

  typedef enum int {
    rd_cont,
    rd_rand,
    rd_after
  } rd_mode_t;

  logic      bus_clk;
  logic      por_rst;
  logic      test_rst;
  logic      rst;
  logic      wr_en;
  msg_word_t wr_data;
  logic      wr_full;
  logic      wr_overflow;
  logic      rd_en;
  msg_word_t rd_data;
  logic      rd_empty;
  logic      rd_eof;

  // **************************************************
  // Test table
  // **************************************************

  string    t_name    [MAX_TESTS];
  int       t_words   [MAX_TESTS];
  rd_mode_t t_mode    [MAX_TESTS];
  bit       t_marker  [MAX_TESTS];
  bit       t_honour  [MAX_TESTS];
  bit       t_exp_ovf [MAX_TESTS];
  int       num_tests;

  // Run state
  msg_word_t   scoreboard [$];
  string       cur_name;
  int          test_errors;
  int          total_errors;
  int          tests_passed;
  int          tests_failed;
  bit          writes_done;
  bit          afull_seen;
  logic [31:0] data_state;
  logic [31:0] rdpat_state;

  assign rst = por_rst || test_rst;

  tb_clock_gen #(
    .PERIOD_NS    (10),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clock_gen (
    .bus_clk (bus_clk),
    .rst     (por_rst)
  );

  host_msg_loop #(
    .IN_DEPTH  (IN_DEPTH),
    .OUT_DEPTH (OUT_DEPTH)
  ) i_host_msg_loop (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .wr_full     (wr_full),
    .wr_overflow (wr_overflow),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .rd_empty    (rd_empty),
    .rd_eof      (rd_eof)
  );

  task automatic add_test(input string name, input int words, input rd_mode_t mode,
                          input bit marker, input bit honour, input bit exp_ovf);
    t_name[num_tests]    = name;
    t_words[num_tests]   = words;
    t_mode[num_tests]    = mode;
    t_marker[num_tests]  = marker;
    t_honour[num_tests]  = honour;
    t_exp_ovf[num_tests] = exp_ovf;
    num_tests++;
  endtask

  // name, words, read mode, end marker, honour wr_full, expected overflow
  task automatic load_table();
    add_test("reset_state",   0,            rd_cont,  1'b0, 1'b1, 1'b0);
    add_test("order",         20,           rd_cont,  1'b0, 1'b1, 1'b0);
    add_test("backpressure",  50,           rd_rand,  1'b0, 1'b1, 1'b0);
    add_test("almost_full",   KEEP_NO_READ, rd_after, 1'b0, 1'b0, 1'b0);
    add_test("overflow",      40,           rd_after, 1'b0, 1'b0, 1'b1);
    add_test("end_of_stream", 10,           rd_after, 1'b1, 1'b1, 1'b0);
    add_test("eof_random",    10,           rd_rand,  1'b1, 1'b1, 1'b0);
  endtask

  // **************************************************
  // Helpers
  // **************************************************

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string what, input msg_word_t expected,
                             input msg_word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s, %s: expected %h, actual %h", cur_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Failure in test %s: %s", cur_name, what);
    test_errors++;
  endtask

  // Inputs change shortly after the edge, outputs are read at the same point
  task automatic next_cycle();
    @(posedge bus_clk);
    #DRIVE_DELAY;
  endtask

  task automatic apply_reset();
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    test_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    #DRIVE_DELAY;
    test_rst = 1'b0;
  endtask

  task automatic write_words(input int count, input bit marker, input bit honour,
                             input bit no_reads);
    int        total;
    int        sent;
    int        stall;
    bit        stuck;
    msg_word_t word;
    total = count + (marker ? 1 : 0);
    sent  = 0;
    stall = 0;
    stuck = 1'b0;
    while (sent < total && !stuck) begin
      if (wr_full && sent < KEEP_NO_READ) begin
        afull_seen = 1'b1;
      end
      if (honour && wr_full) begin
        wr_en = 1'b0;
        stall++;
        if (stall > WAIT_LIMIT) begin
          report_failure("writer held off by wr_full for too long");
          stuck = 1'b1;
        end
      end else begin
        stall = 0;
        if (marker && sent == count) begin
          word = END_MARKER;
        end else begin
          data_state = lcg_step(data_state);
          word       = data_state;
          if (word == END_MARKER) begin
            word = 32'h0000_0001;
          end
        end
        wr_en   = 1'b1;
        wr_data = word;
        // With no reads only the first words survive
        if (word != END_MARKER && (!no_reads || sent < KEEP_NO_READ)) begin
          scoreboard.push_back(word);
        end
        sent++;
      end
      next_cycle();
    end
    wr_en       = 1'b0;
    writes_done = 1'b1;
  endtask

  task automatic read_words(input rd_mode_t mode);
    int        idle;
    bit        take;
    msg_word_t expected;
    idle = 0;
    if (mode == rd_after) begin
      while (!writes_done && idle < RUN_LIMIT) begin
        if (scoreboard.size() != 0) begin
          check_value("rd_eof with words unread", 1'b0, rd_eof);
        end
        next_cycle();
        idle++;
      end
      if (!writes_done) begin
        report_failure("reader gave up waiting for the writer to finish");
      end
      idle = 0;
    end
    while (!(writes_done && scoreboard.size() == 0) && idle <= WAIT_LIMIT) begin
      rd_en = 1'b0;
      take  = 1'b0;
      if (scoreboard.size() != 0) begin
        check_value("rd_eof with words unread", 1'b0, rd_eof);
      end
      if (!rd_empty) begin
        if (rd_data === END_MARKER) begin
          report_failure("end marker showed up at rd_data");
        end
        if (mode == rd_rand) begin
          rdpat_state = lcg_step(rdpat_state);
          take        = rdpat_state[31];
        end else begin
          take = 1'b1;
        end
      end
      if (take) begin
        if (scoreboard.size() == 0) begin
          report_failure("a word came out that was never expected");
        end else begin
          expected = scoreboard.pop_front();
          check_value("rd_data", expected, rd_data);
        end
        rd_en = 1'b1;
        idle  = 0;
      end else begin
        idle++;
      end
      next_cycle();
    end
    rd_en = 1'b0;
    if (scoreboard.size() != 0) begin
      report_failure($sformatf("timed out with %0d words still unread", scoreboard.size()));
    end
  endtask

  // **************************************************
  // One table entry
  // **************************************************

  task automatic run_test(input int idx);
    int cycles;
    cur_name    = t_name[idx];
    test_errors = 0;
    writes_done = 1'b0;
    afull_seen  = 1'b0;
    scoreboard.delete();
    apply_reset();

    check_value("rd_empty after reset", 1'b1, rd_empty);
    check_value("wr_full after reset", 1'b0, wr_full);
    check_value("wr_overflow after reset", 1'b0, wr_overflow);
    check_value("rd_eof after reset", 1'b0, rd_eof);

    fork
      write_words(t_words[idx], t_marker[idx], t_honour[idx], t_mode[idx] == rd_after);
      read_words(t_mode[idx]);
    join

    if (t_marker[idx]) begin
      cycles = 0;
      while (rd_eof !== 1'b1 && cycles < WAIT_LIMIT) begin
        next_cycle();
        cycles++;
      end
      if (rd_eof !== 1'b1) begin
        report_failure("rd_eof never rose after the last read");
      end
    end else begin
      check_value("rd_eof without marker", 1'b0, rd_eof);
    end

    // Nothing beyond the expected words
    for (int i = 0; i < 8; i++) begin
      check_value("rd_empty after drain", 1'b1, rd_empty);
      next_cycle();
    end

    check_value("wr_overflow", t_exp_ovf[idx], wr_overflow);
    if (t_mode[idx] == rd_after && !t_honour[idx]) begin
      check_value("wr_full seen before buffers full", 1'b1, afull_seen);
    end

    if (test_errors == 0) begin
      tests_passed++;
      $display("test %-14s ok", cur_name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", cur_name, test_errors);
    end
    total_errors += test_errors;
  endtask

  initial begin
    int cycles;
    wr_en        = 1'b0;
    wr_data      = '0;
    rd_en        = 1'b0;
    test_rst     = 1'b0;
    data_state   = SEED;
    // Read pattern runs on its own sequence
    rdpat_state  = ~SEED;
    num_tests    = 0;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_errors  = 0;
    cur_name     = "startup";
    load_table();

    cycles = 0;
    while (por_rst !== 1'b0 && cycles < WAIT_LIMIT) begin
      next_cycle();
      cycles++;
    end
    if (por_rst !== 1'b0) begin
      report_failure("power-on reset was never released");
      total_errors += test_errors;
    end else begin
      for (int i = 0; i < num_tests; i++) begin
        run_test(i);
      end
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps

// Free-running bus clock and power-on reset for the testbench
module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic bus_clk,
  output logic rst
);

  initial begin
    bus_clk = 1'b0;
    forever #(PERIOD_NS / 2) bus_clk = ~bus_clk;
  end

  // Released just after an edge, like every other driven input
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- source/host_msg_loop.sv
`timescale 1ns/100ps

// Host message loopback
// write stream -> inbound FIFO -> forwarding stage -> outbound FIFO -> read stream
module host_msg_loop
  import host_msg_pkg::*;
#(
  parameter int IN_DEPTH  = IN_DEPTH_DEFAULT,
  parameter int OUT_DEPTH = OUT_DEPTH_DEFAULT
) (
  input  logic      bus_clk,
  input  logic      rst,

  // Host write stream
  input  logic      wr_en,
  input  msg_word_t wr_data,
  output logic      wr_full,
  output logic      wr_overflow,

  // Host read stream
  input  logic      rd_en,
  output msg_word_t rd_data,
  output logic      rd_empty,
  output logic      rd_eof
);

  // **************************************************
  // Internal path
  // **************************************************

  // Inbound FIFO to forwarding stage
  msg_word_t in_data;
  logic      in_empty;
  logic      in_pop;

  // Forwarding stage to outbound FIFO
  msg_word_t out_data;
  logic      out_push;
  logic      out_full;

  // Host writes land here, almost_full is the warning to the host
  msg_fifo #(
    .DEPTH        (IN_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN_DEFAULT)
  ) i_in_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .din         (wr_data),
    .rd_en       (in_pop),
    .dout        (in_data),
    .empty       (in_empty),
    .full        (),
    .almost_full (wr_full),
    .overflow    (wr_overflow)
  );

  // One word in flight between the FIFOs
  msg_forward i_forward (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_empty  (in_empty),
    .in_pop    (in_pop),
    .out_data  (out_data),
    .out_push  (out_push),
    .out_full  (out_full),
    .out_empty (rd_empty),
    .eof       (rd_eof)
  );

  // Stage honours true full, so no overflow here
  msg_fifo #(
    .DEPTH        (OUT_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN_DEFAULT)
  ) i_out_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (out_push),
    .din         (out_data),
    .rd_en       (rd_en),
    .dout        (rd_data),
    .empty       (rd_empty),
    .full        (out_full),
    .almost_full (),
    .overflow    ()
  );

endmodule

//--- source/msg_forward.sv
`timescale 1ns/100ps

// Moves words from the inbound FIFO to the outbound FIFO
// and strips the end marker
module msg_forward
  import host_msg_pkg::*;
(
  input  logic      bus_clk,
  input  logic      rst,

  // Inbound FIFO head
  input  msg_word_t in_data,
  input  logic      in_empty,
  output logic      in_pop,

  // Outbound FIFO write side
  output msg_word_t out_data,
  output logic      out_push,
  input  logic      out_full,
  input  logic      out_empty,

  // Stream finished and fully drained
  output logic      eof
);

  fwd_state_t state;
  msg_word_t  hold_data;
  logic       hold_valid;
  logic       is_marker;
  logic       load;

  // **************************************************
  // Handshake
  // **************************************************

  // Held word leaves whenever the outbound FIFO has room
  assign out_push = hold_valid && !out_full;
  assign out_data = hold_data;

  // Pop when the register is free or drains this cycle
  assign in_pop = (state == fwd_run) && !in_empty && (!hold_valid || out_push);

  assign is_marker = (in_data == END_MARKER);

  // Only ordinary words reach the register
  assign load = in_pop && !is_marker;

  // Everything before the marker has been read by the host
  assign eof = (state == fwd_ended) && !hold_valid && out_empty;

  // **************************************************
  // FSM
  // **************************************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      state <= fwd_run;
    end else begin
      case (state)
        fwd_run: begin
          // Marker is consumed here and not forwarded
          if (in_pop && is_marker) begin
            state <= fwd_ended;
          end
        end
        fwd_ended: begin
          // Popping stops, leave only through reset
          state <= fwd_ended;
        end
        default: begin
          state <= fwd_run;
        end
      endcase
    end
  end

  // Valid bit of the output register
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else if (load) begin
      hold_valid <= 1'b1;
    end else if (out_push) begin
      hold_valid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge bus_clk) begin
    if (load) begin
      hold_data <= in_data;
    end
  end

endmodule

//--- source/msg_fifo.sv
`timescale 1ns/100ps

// Synchronous FIFO with first-word-fall-through output
module msg_fifo
  import host_msg_pkg::*;
#(
  // Must be a power of two, 4 or more
  parameter int DEPTH        = IN_DEPTH_DEFAULT,
  parameter int AFULL_MARGIN = AFULL_MARGIN_DEFAULT
) (
  input  logic      bus_clk,
  input  logic      rst,

  // Write side
  input  logic      wr_en,
  input  msg_word_t din,

  // Read side, dout valid whenever empty is low
  input  logic      rd_en,
  output msg_word_t dout,
  output logic      empty,

  // Status
  output logic      full,
  output logic      almost_full,
  output logic      overflow
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // **************************************************
  // Storage and pointers
  // **************************************************

  msg_word_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free_slots;
  logic             do_write;
  logic             do_read;

  // A write into a full FIFO is lost
  assign do_write = wr_en && !full;
  assign do_read  = rd_en && !empty;

  // **************************************************
  // Flags
  // **************************************************

  assign free_slots  = CNT_W'(DEPTH) - count;
  assign empty       = (count == '0);
  assign full        = (count == CNT_W'(DEPTH));
  assign almost_full = (free_slots < CNT_W'(AFULL_MARGIN));

  // Head word shows without a read request
  assign dout = mem[rd_ptr];

  // Array write
  always_ff @(posedge bus_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap on their own for a power-of-two depth
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sticky until reset
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      overflow <= 1'b0;
    end else if (wr_en && full) begin
      overflow <= 1'b1;
    end
  end

endmodule

//--- source/host_msg_pkg.sv
// **************************************************
// Host message path shared definitions
// **************************************************

package host_msg_pkg;

  // Width of one host stream word
  localparam int MSG_WIDTH = 32;

  // One message word as carried on both host streams
  typedef logic [MSG_WIDTH-1:0] msg_word_t;

  // All ones closes a stream and is never forwarded
  localparam msg_word_t END_MARKER = '1;

  // **************************************************
  // FIFO sizing
  // **************************************************

  // Entries in the FIFO that takes host writes
  localparam int IN_DEPTH_DEFAULT = 16;

  // Entries in the FIFO that feeds host reads
  localparam int OUT_DEPTH_DEFAULT = 16;

  // almost_full rises once fewer than this many entries are free
  localparam int AFULL_MARGIN_DEFAULT = 2;

  // **************************************************
  // Forwarding stage FSM
  // **************************************************

  // Run until the end marker is seen, then stay ended until reset
  typedef enum logic {
    fwd_run,
    fwd_ended
  } fwd_state_t;

endpackage
